/* verilog/ecc_point_pkg.sv */
`default_nettype none

package ecc_point_pkg;

    localparam int coord_w    = 32;
    localparam int step_idx_w = 5;

    typedef logic [coord_w-1:0]    coord_t;
    typedef logic [step_idx_w-1:0] step_idx_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } ecc_point_t;

    typedef enum logic [1:0] {
        field_add = 2'd0,
        field_sub = 2'd1,
        field_mul = 2'd2,
        field_div = 2'd3
    } field_op_t;

    typedef enum logic [2:0] {
        acc_x   = 3'd0,
        acc_y   = 3'd1,
        base_x  = 3'd2,
        base_y  = 3'd3,
        tmp1    = 3'd4,
        tmp2    = 3'd5,
        new_x   = 3'd6,
        curve_a = 3'd7
    } operand_sel_t;

    typedef enum logic [1:0] {
        to_tmp1  = 2'd0,
        to_tmp2  = 2'd1,
        to_new_x = 2'd2,
        to_new_y = 2'd3
    } dest_sel_t;

    typedef struct packed {
        field_op_t    op;
        operand_sel_t src_a;
        operand_sel_t src_b;
        dest_sel_t    dest;
    } micro_step_t;

    typedef struct packed {
        field_op_t op;
        coord_t    a;
        coord_t    b;
    } field_req_t;

    localparam step_idx_t dbl_first = 5'd0;
    localparam step_idx_t dbl_last  = 5'd11;
    localparam step_idx_t add_first = 5'd12;
    localparam step_idx_t add_last  = 5'd20;

endpackage

`default_nettype wire

/* verilog/ecc_step_rom.sv */
`default_nettype none

module ecc_step_rom (
    input  ecc_point_pkg::step_idx_t   step_idx,
    output ecc_point_pkg::micro_step_t step
);
    import ecc_point_pkg::*;

    // doubling: lambda = (3*ax^2 + a) / (2*ay)
    // addition: lambda = (by - ay) / (bx - ax)
    always_comb
    begin
        case (step_idx)
            5'd0:
                step = '{op: field_mul, src_a: acc_x,  src_b: acc_x,   dest: to_tmp1};  // ax^2
            5'd1:
                step = '{op: field_add, src_a: tmp1,   src_b: tmp1,    dest: to_tmp2};
            5'd2:
                step = '{op: field_add, src_a: tmp1,   src_b: tmp2,    dest: to_tmp1};  // 3ax^2
            5'd3:
                step = '{op: field_add, src_a: tmp1,   src_b: curve_a, dest: to_tmp1};
            5'd4:
                step = '{op: field_add, src_a: acc_y,  src_b: acc_y,   dest: to_tmp2};  // 2ay
            5'd5:
                step = '{op: field_div, src_a: tmp1,   src_b: tmp2,    dest: to_tmp1};  // lambda
            5'd6:
                step = '{op: field_mul, src_a: tmp1,   src_b: tmp1,    dest: to_tmp2};
            5'd7:
                step = '{op: field_sub, src_a: tmp2,   src_b: acc_x,   dest: to_tmp2};
            5'd8:
                step = '{op: field_sub, src_a: tmp2,   src_b: acc_x,   dest: to_new_x};
            5'd9:
                step = '{op: field_sub, src_a: acc_x,  src_b: new_x,   dest: to_tmp2};
            5'd10:
                step = '{op: field_mul, src_a: tmp1,   src_b: tmp2,    dest: to_tmp1};
            5'd11:
                step = '{op: field_sub, src_a: tmp1,   src_b: acc_y,   dest: to_new_y};
            5'd12:
                step = '{op: field_sub, src_a: base_x, src_b: acc_x,   dest: to_tmp1};  // bx - ax
            5'd13:
                step = '{op: field_sub, src_a: base_y, src_b: acc_y,   dest: to_tmp2};  // by - ay
            5'd14:
                step = '{op: field_div, src_a: tmp2,   src_b: tmp1,    dest: to_tmp1};  // lambda
            5'd15:
                step = '{op: field_mul, src_a: tmp1,   src_b: tmp1,    dest: to_tmp2};
            5'd16:
                step = '{op: field_sub, src_a: tmp2,   src_b: acc_x,   dest: to_tmp2};
            5'd17:
                step = '{op: field_sub, src_a: tmp2,   src_b: base_x,  dest: to_new_x};
            5'd18:
                step = '{op: field_sub, src_a: acc_x,  src_b: new_x,   dest: to_tmp2};
            5'd19:
                step = '{op: field_mul, src_a: tmp1,   src_b: tmp2,    dest: to_tmp1};
            5'd20:
                step = '{op: field_sub, src_a: tmp1,   src_b: acc_y,   dest: to_new_y};
            default:
                step = '{op: field_add, src_a: acc_x,  src_b: acc_x,   dest: to_tmp1};  // unused
        endcase
    end

endmodule

`default_nettype wire

/* verilog/ecc_operand_file.sv */
`default_nettype none

module ecc_operand_file (
    input  logic                        clk_p_i,
    input  logic                        reset_n_i,
    input  logic                        point_load,
    input  ecc_point_pkg::ecc_point_t   base_point,
    input  ecc_point_pkg::coord_t       curve_a_in,
    input  ecc_point_pkg::micro_step_t  step,
    input  ecc_point_pkg::coord_t       field_result,
    input  logic                        result_write,
    input  logic                        point_commit,
    output ecc_point_pkg::coord_t       operand_a,
    output ecc_point_pkg::coord_t       operand_b,
    output ecc_point_pkg::ecc_point_t   acc_point
);
    import ecc_point_pkg::*;

    ecc_point_t acc_q;      // point carried between key steps
    ecc_point_t base_q;
    coord_t     curve_a_q;
    coord_t     tmp1_q;
    coord_t     tmp2_q;
    coord_t     new_x_q;
    coord_t     new_y_q;
    coord_t     new_y_next;

    function automatic coord_t pick(operand_sel_t sel);
        coord_t val;
        case (sel)
            acc_x:   val = acc_q.x;
            acc_y:   val = acc_q.y;
            base_x:  val = base_q.x;
            base_y:  val = base_q.y;
            tmp1:    val = tmp1_q;
            tmp2:    val = tmp2_q;
            new_x:   val = new_x_q;
            default: val = curve_a_q;
        endcase
        return val;
    endfunction

    always_comb
    begin
        operand_a = pick(step.src_a);
    end

    always_comb
    begin
        operand_b = pick(step.src_b);
    end

    // last step of a phase writes new_y in the commit cycle itself
    always_comb
    begin
        if (result_write && step.dest == to_new_y)
            new_y_next = field_result;
        else
            new_y_next = new_y_q;
    end

    always_ff @(posedge clk_p_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            acc_q     <= '0;
            base_q    <= '0;
            curve_a_q <= '0;
        end
        else if (point_commit)
        begin
            acc_q <= '{x: new_x_q, y: new_y_next};
        end
        else if (point_load)
        begin
            base_q    <= base_point;
            curve_a_q <= curve_a_in;
            acc_q     <= base_point;   // start from G
        end
    end

    always_ff @(posedge clk_p_i)
    begin
        if (result_write)
        begin
            case (step.dest)
                to_tmp1:  tmp1_q  <= field_result;
                to_tmp2:  tmp2_q  <= field_result;
                to_new_x: new_x_q <= field_result;
                default:  new_y_q <= field_result;
            endcase
        end
    end

    assign acc_point = acc_q;

endmodule

`default_nettype wire

/* verilog/ecc_point_sequencer.sv */
`default_nettype none

module ecc_point_sequencer (
    input  logic                      clk_p_i,
    input  logic                      reset_n_i,
    input  logic                      step_start,
    input  logic                      key_bit,
    input  logic                      field_done,
    output ecc_point_pkg::step_idx_t  step_idx,
    output logic                      field_req_valid,
    output logic                      result_write,
    output logic                      point_commit,
    output logic                      step_done
);
    import ecc_point_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_req,     // request held until field_done
        st_gap      // one low cycle between requests
    } seq_state_t;

    seq_state_t state_q;
    step_idx_t  idx_q;
    logic       key_q;
    logic       done_q;
    logic       phase_end;
    logic       last_step;

    assign field_req_valid = (state_q == st_req);
    assign result_write    = field_req_valid & field_done;
    assign phase_end       = (idx_q == dbl_last) || (idx_q == add_last);
    assign point_commit    = result_write & phase_end;

    // doubling alone ends the key step when the bit is clear
    assign last_step = point_commit & ((idx_q == add_last) | ~key_q);

    assign step_idx  = idx_q;
    assign step_done = done_q;

    always_ff @(posedge clk_p_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            state_q <= st_idle;
            idx_q   <= dbl_first;
            key_q   <= 1'b0;
            done_q  <= 1'b0;
        end
        else
        begin
            done_q <= last_step;
            case (state_q)
                st_idle:
                begin
                    if (step_start)
                    begin
                        state_q <= st_req;
                        idx_q   <= dbl_first;
                        key_q   <= key_bit;
                    end
                end
                st_req:
                begin
                    if (field_done)
                    begin
                        if (last_step)
                        begin
                            state_q <= st_idle;
                        end
                        else
                        begin
                            state_q <= st_gap;
                            if (idx_q == dbl_last)
                                idx_q <= add_first;     // key bit set
                            else
                                idx_q <= idx_q + 1'b1;
                        end
                    end
                end
                st_gap:
                begin
                    state_q <= st_req;
                end
                default:
                begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/ecc_point_unit.sv */
`default_nettype none

module ecc_point_unit (
    input  logic                       clk_p_i,
    input  logic                       reset_n_i,
    input  logic                       point_load,
    input  ecc_point_pkg::ecc_point_t  base_point,
    input  ecc_point_pkg::coord_t      curve_a_in,
    input  logic                       step_start,
    input  logic                       key_bit,
    input  logic                       field_done,
    input  ecc_point_pkg::coord_t      field_result,
    output ecc_point_pkg::field_req_t  field_req,
    output logic                       field_req_valid,
    output logic                       step_done,
    output ecc_point_pkg::ecc_point_t  result_point
);
    import ecc_point_pkg::*;

    step_idx_t   step_idx;
    micro_step_t step;
    logic        result_write;
    logic        point_commit;
    coord_t      operand_a;
    coord_t      operand_b;

    assign field_req = '{op: step.op, a: operand_a, b: operand_b};

    ecc_point_sequencer i_sequencer (
        .clk_p_i         (clk_p_i),
        .reset_n_i       (reset_n_i),
        .step_start      (step_start),
        .key_bit         (key_bit),
        .field_done      (field_done),
        .step_idx        (step_idx),
        .field_req_valid (field_req_valid),
        .result_write    (result_write),
        .point_commit    (point_commit),
        .step_done       (step_done)
    );

    ecc_step_rom i_step_rom (
        .step_idx (step_idx),
        .step     (step)
    );

    ecc_operand_file i_operand_file (
        .clk_p_i      (clk_p_i),
        .reset_n_i    (reset_n_i),
        .point_load   (point_load),
        .base_point   (base_point),
        .curve_a_in   (curve_a_in),
        .step         (step),
        .field_result (field_result),
        .result_write (result_write),
        .point_commit (point_commit),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .acc_point    (result_point)
    );

endmodule

`default_nettype wire

/* verif/ecc_point_unit_props.sv */
`default_nettype none

module ecc_point_unit_props (
    input  logic                       clk_p_i,
    input  logic                       reset_n_i,
    input  ecc_point_pkg::field_req_t  field_req,
    input  logic                       field_req_valid,
    input  logic                       field_done,
    input  logic                       step_done
);
    timeunit 1ns;
    timeprecision 100ps;

    import ecc_point_pkg::*;

    // request held steady until the field unit answers
    a_req_stable: assert property (@(posedge clk_p_i) disable iff (!reset_n_i)
        (field_req_valid && !field_done) |=> $stable(field_req))
        else $error("field_req changed while waiting for field_done");

    a_valid_drop: assert property (@(posedge clk_p_i) disable iff (!reset_n_i)
        field_done |=> !field_req_valid)
        else $error("field_req_valid still high after field_done");

    a_done_pulse: assert property (@(posedge clk_p_i) disable iff (!reset_n_i)
        step_done |=> !step_done)
        else $error("step_done longer than one cycle");

endmodule

`default_nettype wire

/* verif/ecc_point_unit_tb.sv */
`default_nettype none

module ecc_point_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import ecc_point_pkg::*;

    logic       clk_p_i;
    logic       reset_n_i;
    logic       point_load;
    ecc_point_t base_point;
    coord_t     curve_a_in;
    logic       step_start;
    logic       key_bit;
    logic       field_done;
    coord_t     field_result;
    field_req_t field_req;
    logic       field_req_valid;
    logic       step_done;
    ecc_point_t result_point;

    integer     seed = 97557;
    longint     cur_p = 17;       // modulus used by the field model
    int         req_count;
    int         limit_cycles = 0;

    logic [31:0] q_p[$];
    logic [31:0] q_a[$];
    logic [31:0] q_bx[$];
    logic [31:0] q_by[$];
    logic [31:0] q_n[$];
    logic [31:0] q_bits[$];
    logic [31:0] q_ex[$];
    logic [31:0] q_ey[$];

    ecc_point_unit i_ecc_point_unit (
        .clk_p_i         (clk_p_i),
        .reset_n_i       (reset_n_i),
        .point_load      (point_load),
        .base_point      (base_point),
        .curve_a_in      (curve_a_in),
        .step_start      (step_start),
        .key_bit         (key_bit),
        .field_done      (field_done),
        .field_result    (field_result),
        .field_req       (field_req),
        .field_req_valid (field_req_valid),
        .step_done       (step_done),
        .result_point    (result_point)
    );

    bind ecc_point_unit ecc_point_unit_props i_props (
        .clk_p_i         (clk_p_i),
        .reset_n_i       (reset_n_i),
        .field_req       (field_req),
        .field_req_valid (field_req_valid),
        .field_done      (field_done),
        .step_done       (step_done)
    );

    initial
    begin
        clk_p_i = 1'b0;
        forever #5 clk_p_i = ~clk_p_i;
    end

    function automatic longint mod_inverse(longint v, longint m);
        longint t;
        longint new_t;
        longint r;
        longint new_r;
        longint q;
        longint tmp;
        t     = 0;
        new_t = 1;
        r     = m;
        new_r = v % m;
        while (new_r != 0)
        begin
            q     = r / new_r;
            tmp   = t - q * new_t;
            t     = new_t;
            new_t = tmp;
            tmp   = r - q * new_r;
            r     = new_r;
            new_r = tmp;
        end
        if (t < 0)
            t = t + m;
        return t;
    endfunction

    function automatic coord_t field_calc(field_req_t req, longint p);
        longint a;
        longint b;
        longint res;
        a = longint'(req.a);
        b = longint'(req.b);
        case (req.op)
            field_add: res = (a + b) % p;
            field_sub: res = (a + p - b) % p;
            field_mul: res = (a * b) % p;
            default:   res = (a * mod_inverse(b, p)) % p;
        endcase
        return res[31:0];
    endfunction

    // field unit model with 0 to 5 extra cycles per request
    initial
    begin
        int extra;
        field_done   = 1'b0;
        field_result = '0;
        req_count    = 0;
        forever
        begin
            @(posedge clk_p_i);
            #1;
            if (field_req_valid)
            begin
                extra = int'($unsigned($random(seed)) % 6);
                repeat (extra)
                begin
                    @(posedge clk_p_i);
                    #1;
                end
                field_result = field_calc(field_req, cur_p);
                field_done   = 1'b1;
                req_count    = req_count + 1;
                @(posedge clk_p_i);
                #1;
                field_done   = 1'b0;
            end
        end
    end

    initial
    begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk_p_i);
        $display("timeout: the DUT did not finish the key steps in time");
        $display("TEST FAILED");
        $fatal(1);
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic read_stimulus();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] v[8];
        fd = $fopen("verif/ecc_point_unit_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the stimulus file");
            $display("TEST FAILED");
            $fatal(1);
        end
        while ($fgets(line, fd) > 0)
        begin
            if (line.len() < 2 || line.getc(0) == 8'h23)
                continue;   // comment or blank
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h",
                          v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
            if (cnt != 8)
                continue;
            q_p.push_back(v[0]);
            q_a.push_back(v[1]);
            q_bx.push_back(v[2]);
            q_by.push_back(v[3]);
            q_n.push_back(v[4]);
            q_bits.push_back(v[5]);
            q_ex.push_back(v[6]);
            q_ey.push_back(v[7]);
        end
        $fclose(fd);
    endtask

    task automatic run_step(input logic b);
        req_count = 0;
        @(posedge clk_p_i);
        #1;
        step_start = 1'b1;
        key_bit    = b;
        @(posedge clk_p_i);
        #1;
        step_start = 1'b0;
        repeat (3) @(posedge clk_p_i);
        #1;
        step_start = 1'b1;    // arrives while busy, must be ignored
        key_bit    = ~b;
        @(posedge clk_p_i);
        #1;
        step_start = 1'b0;
        while (!step_done)
        begin
            @(posedge clk_p_i);
            #1;
        end
        check_value("req_count", 64'(req_count), b ? 64'd21 : 64'd12);
    endtask

    initial
    begin
        int total_bits;
        reset_n_i  = 1'b0;
        point_load = 1'b0;
        base_point = '0;
        curve_a_in = '0;
        step_start = 1'b0;
        key_bit    = 1'b0;
        read_stimulus();
        if (q_p.size() == 0)
        begin
            $display("the stimulus file holds no test lines");
            $display("TEST FAILED");
            $fatal(1);
        end
        total_bits = 0;
        foreach (q_n[k])
            total_bits = total_bits + int'(q_n[k]);
        limit_cycles = total_bits * 21 * 8 + 100 * q_p.size() + 500;
        repeat (4) @(posedge clk_p_i);
        #1;
        reset_n_i = 1'b1;
        foreach (q_p[k])
        begin
            cur_p = longint'(q_p[k]);
            @(posedge clk_p_i);
            #1;
            point_load = 1'b1;
            base_point = '{x: q_bx[k], y: q_by[k]};
            curve_a_in = q_a[k];
            @(posedge clk_p_i);
            #1;
            point_load = 1'b0;
            check_value("result_point", result_point, {q_bx[k], q_by[k]});
            for (int i = int'(q_n[k]) - 1; i >= 0; i--)
                run_step(q_bits[k][i]);
            check_value("result_point", result_point, {q_ex[k], q_ey[k]});
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/ecc_point_unit_stimulus.txt */
# columns in hex: p a base_x base_y n key_bits expected_x expected_y
# key_bits holds the n bits after the leading one, msb first
11 2 5 1 1 0 6 3
11 2 5 1 1 1 a 6
11 2 5 1 3 5 10 4
11 2 5 1 3 3 d a
11 2 5 1 4 1 6 e
11 2 a 6 2 1 3 10
11 2 0 6 2 2 3 1

/* ecc_point_unit.f */
verilog/ecc_point_pkg.sv
verilog/ecc_step_rom.sv
verilog/ecc_operand_file.sv
verilog/ecc_point_sequencer.sv
verilog/ecc_point_unit.sv
verif/ecc_point_unit_props.sv
verif/ecc_point_unit_tb.sv

/* run_ecc_point_unit.sh */
#!/usr/bin/env bash
# compile and run the ecc_point_unit simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module ecc_point_unit_tb \
    -f ecc_point_unit.f

./obj_dir/Vecc_point_unit_tb
